// ==== verilog/cr_pkg.sv ====
package cr_pkg;

    // ====================
    // Widths and counts
    // ====================
    localparam int XLEN        = 32;                    // Data width
    localparam int NUM_THREADS = 4;                     // Barrel core threads
    localparam int TID_W       = $clog2(NUM_THREADS);   // Thread number width
    localparam int CR_ADDR_W   = 8;                     // Word index on APB
    localparam int CORE_ID_W   = 8;                     // Core-id strap width
    localparam int NUM_SCRATCH = 4;                     // Scratchpad registers

    // ====================
    // Register map
    // ====================
    typedef enum logic [CR_ADDR_W-1:0] {
        CR_THREAD0_PC_RST,
        CR_THREAD1_PC_RST,
        CR_THREAD2_PC_RST,
        CR_THREAD3_PC_RST,
        CR_THREAD0_PC_EN,
        CR_THREAD1_PC_EN,
        CR_THREAD2_PC_EN,
        CR_THREAD3_PC_EN,
        CR_THREAD0_STACK_OFST,
        CR_THREAD1_STACK_OFST,
        CR_THREAD2_STACK_OFST,
        CR_THREAD3_STACK_OFST,
        CR_THREAD0_TLS_OFST,
        CR_THREAD1_TLS_OFST,
        CR_THREAD2_TLS_OFST,
        CR_THREAD3_TLS_OFST,
        CR_SHARED_OFST,
        CR_SCRATCHPAD0,
        CR_SCRATCHPAD1,
        CR_SCRATCHPAD2,
        CR_SCRATCHPAD3,         // Last writable entry
        CR_THREAD_ID,
        CR_CORE_ID,
        CR_CUR_STACK_OFST,
        CR_CUR_TLS_OFST,
        CR_THREAD0_PC,
        CR_THREAD1_PC,
        CR_THREAD2_PC,
        CR_THREAD3_PC           // Last mapped entry
    } cr_addr_e;

    // Anything past CR_LAST_RW is read only, anything past CR_LAST is unmapped
    localparam cr_addr_e CR_LAST_RW = CR_SCRATCHPAD3;
    localparam cr_addr_e CR_LAST    = CR_THREAD3_PC;

endpackage

// ==== verilog/cr_rw_regs.sv ====
`timescale 1ns/1ps

module cr_rw_regs #(
    parameter logic [cr_pkg::XLEN-1:0] STK_RST_BASE  = 32'h400200,
    parameter logic [cr_pkg::XLEN-1:0] THREAD_STRIDE = 32'h200,
    parameter logic [cr_pkg::XLEN-1:0] SHRD_RST      = 32'h400f00
) (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          wr_en,
    input  logic [cr_pkg::CR_ADDR_W-1:0]                  wr_addr,
    input  logic [cr_pkg::XLEN-1:0]                       wr_data,
    output logic [cr_pkg::NUM_THREADS-1:0]                thread_rst,
    output logic [cr_pkg::NUM_THREADS-1:0]                thread_en,
    output logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   stk_ofst,
    output logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   tls_ofst,
    output logic [cr_pkg::XLEN-1:0]                       shrd_ofst,
    output logic [cr_pkg::NUM_SCRATCH*cr_pkg::XLEN-1:0]   scratch
);

    localparam int XLEN = cr_pkg::XLEN;
    localparam int NT   = cr_pkg::NUM_THREADS;

    cr_pkg::cr_addr_e wr_sel;

    assign wr_sel = cr_pkg::cr_addr_e'(wr_addr);

    // ====================
    // Register bank
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thread_rst <= '1;                           // Threads come up held in reset
            thread_en  <= '1;
            for (int i = 0; i < NT; i++) begin
                stk_ofst[i*XLEN +: XLEN] <= XLEN'(STK_RST_BASE + i * THREAD_STRIDE);
                tls_ofst[i*XLEN +: XLEN] <= XLEN'(STK_RST_BASE + i * THREAD_STRIDE);
            end
            shrd_ofst <= SHRD_RST;
            scratch   <= '0;
        end else if (wr_en) begin
            case (wr_sel)
                cr_pkg::CR_THREAD0_PC_RST     : thread_rst[0] <= wr_data[0];
                cr_pkg::CR_THREAD1_PC_RST     : thread_rst[1] <= wr_data[0];
                cr_pkg::CR_THREAD2_PC_RST     : thread_rst[2] <= wr_data[0];
                cr_pkg::CR_THREAD3_PC_RST     : thread_rst[3] <= wr_data[0];
                cr_pkg::CR_THREAD0_PC_EN      : thread_en[0]  <= wr_data[0];
                cr_pkg::CR_THREAD1_PC_EN      : thread_en[1]  <= wr_data[0];
                cr_pkg::CR_THREAD2_PC_EN      : thread_en[2]  <= wr_data[0];
                cr_pkg::CR_THREAD3_PC_EN      : thread_en[3]  <= wr_data[0];
                cr_pkg::CR_THREAD0_STACK_OFST : stk_ofst[0*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD1_STACK_OFST : stk_ofst[1*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD2_STACK_OFST : stk_ofst[2*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD3_STACK_OFST : stk_ofst[3*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD0_TLS_OFST   : tls_ofst[0*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD1_TLS_OFST   : tls_ofst[1*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD2_TLS_OFST   : tls_ofst[2*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_THREAD3_TLS_OFST   : tls_ofst[3*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_SHARED_OFST        : shrd_ofst <= wr_data;
                cr_pkg::CR_SCRATCHPAD0        : scratch[0*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_SCRATCHPAD1        : scratch[1*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_SCRATCHPAD2        : scratch[2*XLEN +: XLEN] <= wr_data;
                cr_pkg::CR_SCRATCHPAD3        : scratch[3*XLEN +: XLEN] <= wr_data;
                default                       : ;       // Read-only or unmapped
            endcase
        end
    end

endmodule

// ==== verilog/cr_thread_capture.sv ====
`timescale 1ns/1ps

module cr_thread_capture (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic [cr_pkg::NUM_THREADS-1:0]                thread_onehot,
    input  logic [cr_pkg::XLEN-1:0]                       pc,
    input  logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   stk_ofst,
    input  logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   tls_ofst,
    output logic [cr_pkg::TID_W-1:0]                      cur_tid,
    output logic [cr_pkg::XLEN-1:0]                       cur_stk,
    output logic [cr_pkg::XLEN-1:0]                       cur_tls,
    output logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   pc_regs
);

    localparam int XLEN  = cr_pkg::XLEN;
    localparam int NT    = cr_pkg::NUM_THREADS;
    localparam int TID_W = cr_pkg::TID_W;

    logic [NT-1:0]    cap_onehot;                       // Thread in the capture stage
    logic [TID_W-1:0] cap_tid;

    // ====================
    // Thread decode
    // ====================
    // The input runs one stage ahead, so step it back by one thread
    always_comb begin
        for (int j = 0; j < NT; j++) begin
            cap_onehot[j] = thread_onehot[(j + 1) % NT];
        end
    end

    always_comb begin
        cap_tid = TID_W'(NT - 1);                       // Also covers a non one-hot input
        for (int j = 0; j < NT - 1; j++) begin
            if (cap_onehot == (NT'(1) << j)) begin
                cap_tid = TID_W'(j);
            end
        end
    end

    // ====================
    // Capture registers
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_tid <= '0;
            cur_stk <= '0;
            cur_tls <= '0;
            pc_regs <= '0;
        end else begin
            cur_tid <= cap_tid;
            cur_stk <= stk_ofst[cap_tid*XLEN +: XLEN];  // Offsets of the running thread
            cur_tls <= tls_ofst[cap_tid*XLEN +: XLEN];
            pc_regs[cap_tid*XLEN +: XLEN] <= pc;        // One thread updates per cycle
        end
    end

endmodule

// ==== verilog/cr_read_mux.sv ====
`timescale 1ns/1ps

module cr_read_mux (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          rd_sample,
    input  logic [cr_pkg::CR_ADDR_W-1:0]                  rd_addr,
    input  logic                                          rd_write,
    input  logic [cr_pkg::NUM_THREADS-1:0]                thread_rst,
    input  logic [cr_pkg::NUM_THREADS-1:0]                thread_en,
    input  logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   stk_ofst,
    input  logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   tls_ofst,
    input  logic [cr_pkg::XLEN-1:0]                       shrd_ofst,
    input  logic [cr_pkg::NUM_SCRATCH*cr_pkg::XLEN-1:0]   scratch,
    input  logic [cr_pkg::TID_W-1:0]                      cur_tid,
    input  logic [cr_pkg::XLEN-1:0]                       cur_stk,
    input  logic [cr_pkg::XLEN-1:0]                       cur_tls,
    input  logic [cr_pkg::NUM_THREADS*cr_pkg::XLEN-1:0]   pc_regs,
    input  logic [cr_pkg::CORE_ID_W-1:0]                  core_id,
    output logic [cr_pkg::XLEN-1:0]                       prdata,
    output logic                                          pslverr
);

    localparam int XLEN  = cr_pkg::XLEN;
    localparam int TID_W = cr_pkg::TID_W;

    logic [XLEN-1:0] rd_data;
    logic            rd_err;

    // Position of an address inside a group of four registers
    function automatic logic [TID_W-1:0] grp_idx(
        input logic [cr_pkg::CR_ADDR_W-1:0] addr,
        input logic [cr_pkg::CR_ADDR_W-1:0] base
    );
        logic [cr_pkg::CR_ADDR_W-1:0] diff;
        diff = addr - base;
        return diff[TID_W-1:0];
    endfunction

    // ====================
    // Address decode
    // ====================
    always_comb begin
        rd_data = '0;
        case (rd_addr) inside
            [cr_pkg::CR_THREAD0_PC_RST : cr_pkg::CR_THREAD3_PC_RST] :
                rd_data = XLEN'(thread_rst[grp_idx(rd_addr, cr_pkg::CR_THREAD0_PC_RST)]);
            [cr_pkg::CR_THREAD0_PC_EN : cr_pkg::CR_THREAD3_PC_EN] :
                rd_data = XLEN'(thread_en[grp_idx(rd_addr, cr_pkg::CR_THREAD0_PC_EN)]);
            [cr_pkg::CR_THREAD0_STACK_OFST : cr_pkg::CR_THREAD3_STACK_OFST] :
                rd_data = stk_ofst[grp_idx(rd_addr, cr_pkg::CR_THREAD0_STACK_OFST)*XLEN +: XLEN];
            [cr_pkg::CR_THREAD0_TLS_OFST : cr_pkg::CR_THREAD3_TLS_OFST] :
                rd_data = tls_ofst[grp_idx(rd_addr, cr_pkg::CR_THREAD0_TLS_OFST)*XLEN +: XLEN];
            cr_pkg::CR_SHARED_OFST    : rd_data = shrd_ofst;
            [cr_pkg::CR_SCRATCHPAD0 : cr_pkg::CR_SCRATCHPAD3] :
                rd_data = scratch[grp_idx(rd_addr, cr_pkg::CR_SCRATCHPAD0)*XLEN +: XLEN];
            cr_pkg::CR_THREAD_ID      : rd_data = XLEN'(cur_tid);
            cr_pkg::CR_CORE_ID        : rd_data = XLEN'(core_id);   // Strap read straight through
            cr_pkg::CR_CUR_STACK_OFST : rd_data = cur_stk;
            cr_pkg::CR_CUR_TLS_OFST   : rd_data = cur_tls;
            [cr_pkg::CR_THREAD0_PC : cr_pkg::CR_THREAD3_PC] :
                rd_data = pc_regs[grp_idx(rd_addr, cr_pkg::CR_THREAD0_PC)*XLEN +: XLEN];
            default                   : rd_data = '0;
        endcase
    end

    assign rd_err = (rd_addr > cr_pkg::CR_LAST) || (rd_write && rd_addr > cr_pkg::CR_LAST_RW);

    // ====================
    // Read data register
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (rd_sample) begin
            prdata  <= rd_write ? '0 : rd_data;         // Writes return no data
            pslverr <= rd_err;
        end
    end

endmodule

// ==== verilog/cr_mem.sv ====
`timescale 1ns/1ps

module cr_mem #(
    parameter logic [cr_pkg::XLEN-1:0] STK_RST_BASE  = 32'h400200,
    parameter logic [cr_pkg::XLEN-1:0] THREAD_STRIDE = 32'h200,
    parameter logic [cr_pkg::XLEN-1:0] SHRD_RST      = 32'h400f00
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [cr_pkg::CR_ADDR_W-1:0]      paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cr_pkg::XLEN-1:0]           pwdata,
    output logic [cr_pkg::XLEN-1:0]           prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic [cr_pkg::NUM_THREADS-1:0]    thread_onehot,
    input  logic [cr_pkg::XLEN-1:0]           pc,
    input  logic [cr_pkg::CORE_ID_W-1:0]      core_id,
    output logic [cr_pkg::NUM_THREADS-1:0]    thread_rst,
    output logic [cr_pkg::NUM_THREADS-1:0]    thread_en
);

    localparam int XLEN = cr_pkg::XLEN;
    localparam int NT   = cr_pkg::NUM_THREADS;

    logic                                 wr_en;
    logic                                 rd_sample;
    logic [NT*XLEN-1:0]                   stk_ofst;
    logic [NT*XLEN-1:0]                   tls_ofst;
    logic [XLEN-1:0]                      shrd_ofst;
    logic [cr_pkg::NUM_SCRATCH*XLEN-1:0]  scratch;
    logic [cr_pkg::TID_W-1:0]             cur_tid;
    logic [XLEN-1:0]                      cur_stk;
    logic [XLEN-1:0]                      cur_tls;
    logic [NT*XLEN-1:0]                   pc_regs;

    // ====================
    // APB phases
    // ====================
    assign pready    = 1'b1;                            // Zero wait states
    assign wr_en     = psel & penable & pwrite;         // Write lands at end of access
    assign rd_sample = psel & ~penable;                 // Setup cycle

    cr_rw_regs #(
        .STK_RST_BASE  (STK_RST_BASE),
        .THREAD_STRIDE (THREAD_STRIDE),
        .SHRD_RST      (SHRD_RST)
    ) u_rw_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (paddr),
        .wr_data    (pwdata),
        .thread_rst (thread_rst),
        .thread_en  (thread_en),
        .stk_ofst   (stk_ofst),
        .tls_ofst   (tls_ofst),
        .shrd_ofst  (shrd_ofst),
        .scratch    (scratch)
    );

    cr_thread_capture u_thread_capture (
        .clk           (clk),
        .arst_n        (arst_n),
        .thread_onehot (thread_onehot),
        .pc            (pc),
        .stk_ofst      (stk_ofst),
        .tls_ofst      (tls_ofst),
        .cur_tid       (cur_tid),
        .cur_stk       (cur_stk),
        .cur_tls       (cur_tls),
        .pc_regs       (pc_regs)
    );

    cr_read_mux u_read_mux (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_sample  (rd_sample),
        .rd_addr    (paddr),
        .rd_write   (pwrite),
        .thread_rst (thread_rst),
        .thread_en  (thread_en),
        .stk_ofst   (stk_ofst),
        .tls_ofst   (tls_ofst),
        .shrd_ofst  (shrd_ofst),
        .scratch    (scratch),
        .cur_tid    (cur_tid),
        .cur_stk    (cur_stk),
        .cur_tls    (cur_tls),
        .pc_regs    (pc_regs),
        .core_id    (core_id),
        .prdata     (prdata),
        .pslverr    (pslverr)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;                                  // Held low from time zero
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

// ==== bench/tb_cr_mem.sv ====
`timescale 1ns/1ps

module tb_cr_mem;

    localparam logic [31:0] STK_RST_BASE  = 32'h400200;
    localparam logic [31:0] THREAD_STRIDE = 32'h200;
    localparam logic [31:0] SHRD_RST      = 32'h400f00;
    localparam logic [7:0]  CORE_ID       = 8'h5a;
    localparam int XFER_BUDGET     = 200;               // Well above the transfers issued below
    localparam int WATCHDOG_CYCLES = XFER_BUDGET * 2 * 5;

    localparam int A_RST0    = int'(cr_pkg::CR_THREAD0_PC_RST);
    localparam int A_EN0     = int'(cr_pkg::CR_THREAD0_PC_EN);
    localparam int A_STK0    = int'(cr_pkg::CR_THREAD0_STACK_OFST);
    localparam int A_TLS0    = int'(cr_pkg::CR_THREAD0_TLS_OFST);
    localparam int A_LAST_RW = int'(cr_pkg::CR_SCRATCHPAD3);
    localparam int A_TID     = int'(cr_pkg::CR_THREAD_ID);
    localparam int A_CORE    = int'(cr_pkg::CR_CORE_ID);
    localparam int A_CSTK    = int'(cr_pkg::CR_CUR_STACK_OFST);
    localparam int A_CTLS    = int'(cr_pkg::CR_CUR_TLS_OFST);
    localparam int A_PC0     = int'(cr_pkg::CR_THREAD0_PC);
    localparam int A_LAST    = int'(cr_pkg::CR_THREAD3_PC);

    logic clk;
    logic arst_n;
    logic [cr_pkg::CR_ADDR_W-1:0]   paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [31:0]                    pwdata;
    logic [31:0]                    prdata;
    logic                           pready;
    logic                           pslverr;
    logic [3:0]                     thread_onehot;
    logic [31:0]                    pc;
    logic [7:0]                     core_id;
    logic [3:0]                     thread_rst;
    logic [3:0]                     thread_en;

    logic [31:0] m_reg [0:A_LAST_RW];                   // Model of the writable registers
    logic [31:0] m_pc  [0:3];
    logic [31:0] exp_prdata;
    logic        exp_pslverr;
    logic [3:0]  exp_rst;
    logic [3:0]  exp_en;

    tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(2)) u_clk_gen (.clk(clk), .arst_n(arst_n));

    cr_mem #(
        .STK_RST_BASE  (STK_RST_BASE),
        .THREAD_STRIDE (THREAD_STRIDE),
        .SHRD_RST      (SHRD_RST)
    ) DUT (
        .clk(clk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .thread_onehot(thread_onehot), .pc(pc), .core_id(core_id),
        .thread_rst(thread_rst), .thread_en(thread_en)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // ====================
    // Checks
    // ====================
    prdata_check: assert property (@(negedge clk) disable iff (!arst_n)
        !(psel && penable) || prdata == exp_prdata)
        else report_mismatch("prdata", prdata, exp_prdata);
    pslverr_check: assert property (@(negedge clk) disable iff (!arst_n)
        !(psel && penable) || pslverr == exp_pslverr)
        else report_mismatch("pslverr", 32'(pslverr), 32'(exp_pslverr));
    rst_check: assert property (@(negedge clk) disable iff (!arst_n) thread_rst == exp_rst)
        else report_mismatch("thread_rst", 32'(thread_rst), 32'(exp_rst));
    en_check: assert property (@(negedge clk) disable iff (!arst_n) thread_en == exp_en)
        else report_mismatch("thread_en", 32'(thread_en), 32'(exp_en));
    pready_check: assert property (@(negedge clk) disable iff (!arst_n) pready)
        else report_mismatch("pready", 32'(pready), 32'd1);

    // One setup cycle then one access cycle, expectations held for the access cycle
    task automatic transfer(input int addr, input logic wr, input logic [31:0] data,
                            input logic [31:0] exp_data, input logic exp_err);
        paddr       = 8'(addr);
        pwrite      = wr;
        pwdata      = data;
        psel        = 1'b1;
        penable     = 1'b0;
        exp_prdata  = exp_data;
        exp_pslverr = exp_err;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_reg(input int addr, input logic [31:0] exp_data, input logic exp_err);
        transfer(addr, 1'b0, 32'h0, exp_data, exp_err);
    endtask

    task automatic write_reg(input int addr, input logic [31:0] data, input logic exp_err);
        transfer(addr, 1'b1, data, 32'h0, exp_err);
        if (!exp_err) begin
            m_reg[addr] = (addr < A_STK0) ? {31'b0, data[0]} : data;    // Control bits keep bit 0
        end
        for (int n = 0; n < 4; n++) begin
            exp_rst[n] = m_reg[A_RST0 + n][0];
            exp_en[n]  = m_reg[A_EN0 + n][0];
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] seed_ret;
        seed_ret      = $urandom(44);
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        thread_onehot = 4'b0001;
        pc            = '0;
        core_id       = CORE_ID;
        exp_prdata    = '0;
        exp_pslverr   = 1'b0;
        exp_rst       = 4'hf;                           // Threads come up in reset and enabled
        exp_en        = 4'hf;
        for (int n = 0; n < 4; n++) begin
            m_reg[A_RST0 + n] = 32'd1;
            m_reg[A_EN0 + n]  = 32'd1;
            m_reg[A_STK0 + n] = STK_RST_BASE + n * THREAD_STRIDE;
            m_reg[A_TLS0 + n] = STK_RST_BASE + n * THREAD_STRIDE;
            m_reg[int'(cr_pkg::CR_SCRATCHPAD0) + n] = '0;
        end
        m_reg[int'(cr_pkg::CR_SHARED_OFST)] = SHRD_RST;
        wait (arst_n);
        @(posedge clk);
        #1;

        // ====================
        // Reset values and readback
        // ====================
        for (int a = 0; a <= A_LAST_RW; a++) read_reg(a, m_reg[a], 1'b0);
        read_reg(A_CORE, 32'(CORE_ID), 1'b0);
        for (int a = 0; a <= A_LAST_RW; a++) write_reg(a, $urandom, 1'b0);
        for (int a = 0; a <= A_LAST_RW; a++) read_reg(a, m_reg[a], 1'b0);
        for (int a = A_RST0; a < A_STK0; a++) write_reg(a, $urandom, 1'b0);  // Toggle outputs

        // ====================
        // Thread capture
        // ====================
        for (int k = 0; k < 8; k++) begin
            thread_onehot = 4'(1 << (k % 4));
            pc            = $urandom;
            m_pc[(k + 3) % 4] = pc;                     // Input runs one thread ahead
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        for (int n = 0; n < 4; n++) read_reg(A_PC0 + n, m_pc[n], 1'b0);
        for (int i = 0; i < 4; i++) begin
            thread_onehot     = 4'(1 << i);
            m_pc[(i + 3) % 4] = pc;
            repeat (2) @(posedge clk);
            #1;
            read_reg(A_TID, 32'((i + 3) % 4), 1'b0);
            read_reg(A_CSTK, m_reg[A_STK0 + (i + 3) % 4], 1'b0);
            read_reg(A_CTLS, m_reg[A_TLS0 + (i + 3) % 4], 1'b0);
        end

        // ====================
        // Error responses
        // ====================
        read_reg(A_LAST + 1, 32'h0, 1'b1);
        read_reg(255, 32'h0, 1'b1);
        write_reg(A_TID, $urandom, 1'b1);
        write_reg(A_CORE, $urandom, 1'b1);
        write_reg(A_PC0 + 1, $urandom, 1'b1);
        write_reg(128, $urandom, 1'b1);
        read_reg(A_TID, 32'd2, 1'b0);                   // Bit 3 still held, so thread 2
        read_reg(A_CORE, 32'(CORE_ID), 1'b0);
        for (int n = 0; n < 4; n++) read_reg(A_PC0 + n, m_pc[n], 1'b0);
        for (int a = 0; a <= A_LAST_RW; a++) read_reg(a, m_reg[a], 1'b0);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/cr_pkg.sv
verilog/cr_rw_regs.sv
verilog/cr_thread_capture.sv
verilog/cr_read_mux.sv
verilog/cr_mem.sv
bench/tb_clk_gen.sv
bench/tb_cr_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cr_mem -f sources.f
sim_status=0
./obj_dir/Vtb_cr_mem > sim.log 2>&1 || sim_status=$?
cat sim.log
if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
